//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Verification passed

SRCS := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides pass or fail
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- source/bus_pkg.sv
`default_nettype none

// read port between stage controller and data memory
package bus_pkg;

    // cycles of req high before the memory raises ack
    localparam int RSP_DELAY = 2;
    // counter must reach RSP_DELAY-1, sized with one spare value
    localparam int DLY_W = $clog2(RSP_DELAY + 1);

    typedef logic [DLY_W-1:0] dly_t;

    // index travels with req, held stable until ack
    typedef struct packed {
        mem_pkg::word_idx_t idx;
    } rd_req_t;

    // word travels with ack
    typedef struct packed {
        mem_pkg::xlen_t data;
    } rd_rsp_t;

endpackage

`default_nettype wire

//--- source/data_mem.sv
`default_nettype none

module data_mem (
    input  wire logic               clk,
    input  wire logic               rst_n,
    // preload port
    input  wire logic               init_we,
    input  mem_pkg::word_idx_t      init_idx,
    input  mem_pkg::xlen_t          init_data,
    // four-phase read responder
    input  wire logic               mem_req,
    input  bus_pkg::rd_req_t        rd_req,
    output logic                    mem_ack,
    output bus_pkg::rd_rsp_t        rd_rsp
);

    mem_pkg::xlen_t mem [mem_pkg::MEM_WORDS];
    bus_pkg::dly_t  cnt_q;
    logic           ack_q;
    logic           fire;

    // word is ready once req has been seen RSP_DELAY times
    assign fire = mem_req && !ack_q && (cnt_q == bus_pkg::dly_t'(bus_pkg::RSP_DELAY - 1));

    // delay counter and ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
            ack_q <= 1'b0;
        end else if (fire) begin
            cnt_q <= '0;
            ack_q <= 1'b1;
        end else if (mem_req && !ack_q) begin
            cnt_q <= cnt_q + 1'b1;
        end else if (ack_q && !mem_req) begin
            // phase 4
            ack_q <= 1'b0;
        end
    end

    // init writes
    always_ff @(posedge clk) begin
        if (init_we) begin
            mem[init_idx] <= init_data;
        end
    end

    // response word, stable while ack is high
    always_ff @(posedge clk) begin
        if (fire) begin
            rd_rsp.data <= mem[rd_req.idx];
        end
    end

    assign mem_ack = ack_q;

endmodule

`default_nettype wire

//--- source/load_ctrl.sv
`default_nettype none

module load_ctrl (
    input  wire logic               clk,
    input  wire logic               rst_n,
    // op from upstream
    input  wire logic               in_valid,
    input  mem_pkg::stage_in_t      in_op,
    output logic                    in_ready,
    // four-phase read port
    output logic                    mem_req,
    output bus_pkg::rd_req_t        rd_req,
    input  wire logic               mem_ack,
    input  bus_pkg::rd_rsp_t        rd_rsp,
    // latched op and word for the extender
    output mem_pkg::stage_in_t      op_q,
    output mem_pkg::xlen_t          word_q,
    output mem_pkg::lane_t          lane,
    output logic                    wb_valid
);

    mem_pkg::stage_state_e state_q;
    mem_pkg::stage_state_e state_d;
    mem_pkg::addr_t        addr_q;
    logic                  accept;

    assign accept = in_valid && in_ready;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_pkg::ST_IDLE: begin
                if (accept) begin
                    // non-loads go straight to writeback
                    if (in_op.kind == mem_pkg::LD_NONE) begin
                        state_d = mem_pkg::ST_DONE;
                    end else begin
                        state_d = mem_pkg::ST_REQ;
                    end
                end
            end
            mem_pkg::ST_REQ: begin
                // phase 2 seen, data gets latched this edge
                if (mem_ack) begin
                    state_d = mem_pkg::ST_RELEASE;
                end
            end
            mem_pkg::ST_RELEASE: begin
                // phase 4, wait for ack to fall
                if (!mem_ack) begin
                    state_d = mem_pkg::ST_DONE;
                end
            end
            mem_pkg::ST_DONE: begin
                state_d = mem_pkg::ST_IDLE;
            end
            default: begin
                state_d = mem_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= mem_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // op and effective address latched on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= in_op;
            addr_q <= in_op.base + in_op.offset;
        end
    end

    // memory word captured on the ack edge
    always_ff @(posedge clk) begin
        if (state_q == mem_pkg::ST_REQ && mem_ack) begin
            word_q <= rd_rsp.data;
        end
    end

    // req only in ST_REQ, so it drops the edge after ack
    assign mem_req    = (state_q == mem_pkg::ST_REQ);
    assign rd_req.idx = addr_q[mem_pkg::IDX_LSB +: mem_pkg::IDX_W];
    assign lane       = addr_q[mem_pkg::LANE_W-1:0];

    assign in_ready = (state_q == mem_pkg::ST_IDLE);
    // single cycle pulse
    assign wb_valid = (state_q == mem_pkg::ST_DONE);

endmodule

`default_nettype wire

//--- source/load_extend.sv
`default_nettype none

module load_extend (
    input  mem_pkg::stage_in_t op,
    input  mem_pkg::xlen_t     word,
    input  mem_pkg::lane_t     lane,
    output mem_pkg::wb_t       wb
);

    mem_pkg::xlen_t shifted;

    // bring the addressed byte down to bit 0
    assign shifted = word >> {lane, 3'b000};

    always_comb begin
        wb.is_load = (op.kind != mem_pkg::LD_NONE);
        case (op.kind)
            // byte
            mem_pkg::LD_B: begin
                wb.data = {{56{shifted[7]}}, shifted[7:0]};
            end
            mem_pkg::LD_BU: begin
                wb.data = {56'd0, shifted[7:0]};
            end
            // half
            mem_pkg::LD_H: begin
                wb.data = {{48{shifted[15]}}, shifted[15:0]};
            end
            mem_pkg::LD_HU: begin
                wb.data = {48'd0, shifted[15:0]};
            end
            // word
            mem_pkg::LD_W: begin
                wb.data = {{32{shifted[31]}}, shifted[31:0]};
            end
            mem_pkg::LD_WU: begin
                wb.data = {32'd0, shifted[31:0]};
            end
            // lane is zero for an aligned ld
            mem_pkg::LD_D: begin
                wb.data = shifted;
            end
            // no memory access, alu result passes through
            default: begin
                wb.data = op.alu_res;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

// shared types for the load side of the memory stage
package mem_pkg;

    // data path and address widths
    localparam int XLEN = 64;
    localparam int ADDR_W = 64;
    // memory geometry, one 64-bit word per index
    localparam int MEM_WORDS = 256;
    localparam int IDX_W = 8;
    // byte offset inside a word
    localparam int LANE_W = 3;
    localparam int IDX_LSB = LANE_W;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [IDX_W-1:0] word_idx_t;
    typedef logic [LANE_W-1:0] lane_t;

    // LD_NONE means the op skips memory and writes back alu_res
    typedef enum logic [2:0] {
        LD_NONE,
        LD_B,
        LD_BU,
        LD_H,
        LD_HU,
        LD_W,
        LD_WU,
        LD_D
    } load_kind_e;

    // one op handed in from the execute side
    typedef struct packed {
        load_kind_e kind;
        xlen_t      base;
        xlen_t      offset;
        xlen_t      alu_res;
    } stage_in_t;

    typedef struct packed {
        xlen_t data;
        logic  is_load;
    } wb_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_RELEASE,
        ST_DONE
    } stage_state_e;

endpackage

`default_nettype wire

//--- source/mem_stage_top.sv
`default_nettype none

module mem_stage_top (
    input  wire logic               clk,
    input  wire logic               rst_n,
    // op handshake
    input  wire logic               in_valid,
    input  mem_pkg::stage_in_t      in_op,
    output logic                    in_ready,
    // preload
    input  wire logic               init_we,
    input  mem_pkg::word_idx_t      init_idx,
    input  mem_pkg::xlen_t          init_data,
    // writeback, no back-pressure
    output logic                    wb_valid,
    output mem_pkg::wb_t            wb
);

    logic               mem_req;
    logic               mem_ack;
    bus_pkg::rd_req_t   rd_req;
    bus_pkg::rd_rsp_t   rd_rsp;
    mem_pkg::stage_in_t op_q;
    mem_pkg::xlen_t     word_q;
    mem_pkg::lane_t     lane;

    load_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_ready (in_ready),
        .mem_req  (mem_req),
        .rd_req   (rd_req),
        .mem_ack  (mem_ack),
        .rd_rsp   (rd_rsp),
        .op_q     (op_q),
        .word_q   (word_q),
        .lane     (lane),
        .wb_valid (wb_valid)
    );

    data_mem u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .init_we   (init_we),
        .init_idx  (init_idx),
        .init_data (init_data),
        .mem_req   (mem_req),
        .rd_req    (rd_req),
        .mem_ack   (mem_ack),
        .rd_rsp    (rd_rsp)
    );

    // wb is sampled with wb_valid
    load_extend u_ext (
        .op   (op_q),
        .word (word_q),
        .lane (lane),
        .wb   (wb)
    );

endmodule

`default_nettype wire

//--- sources.f
source/mem_pkg.sv
source/bus_pkg.sv
source/load_ctrl.sv
source/data_mem.sv
source/load_extend.sv
source/mem_stage_top.sv
testbench/mem_stage_asserts.sv
testbench/mem_stage_tb.sv

//--- testbench/mem_stage_asserts.sv
`default_nettype none

// handshake and stage control checks bound into load_ctrl
module mem_stage_asserts (
    input wire logic                  clk,
    input wire logic                  rst_n,
    input wire logic                  in_ready,
    input wire logic                  mem_req,
    input wire logic                  mem_ack,
    input wire logic                  wb_valid,
    input wire mem_pkg::stage_state_e state_q,
    input wire mem_pkg::stage_in_t    op_q,
    input wire mem_pkg::lane_t        lane
);

    // count of failed assertions
    int fails = 0;

    // lane must be a multiple of the access width
    function automatic logic lane_ok(mem_pkg::load_kind_e k, mem_pkg::lane_t l);
        if (k == mem_pkg::LD_H || k == mem_pkg::LD_HU) begin
            return l[0] == 1'b0;
        end else if (k == mem_pkg::LD_W || k == mem_pkg::LD_WU) begin
            return l[1:0] == 2'b00;
        end else if (k == mem_pkg::LD_D) begin
            return l == 3'd0;
        end
        return 1'b1;
    endfunction

    // req held from phase 1 until ack
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req)
        else begin
            fails++;
            $error("mem_req dropped before mem_ack");
        end

    ack_under_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_ack) |-> mem_req)
        else begin
            fails++;
            $error("mem_ack rose without mem_req");
        end

    wb_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |=> !wb_valid)
        else begin
            fails++;
            $error("wb_valid longer than one cycle");
        end

    // memory still holding ack means the stage is mid handshake
    // no new op taken and writeback waits for phase 4
    busy_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ack |-> !in_ready && state_q != mem_pkg::ST_DONE)
        else begin
            fails++;
            $error("stage left the handshake while mem_ack was high");
        end

    addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> lane_ok(op_q.kind, lane))
        else begin
            fails++;
            $error("load address not aligned to its width");
        end

endmodule

bind load_ctrl mem_stage_asserts u_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_ready (in_ready),
    .mem_req  (mem_req),
    .mem_ack  (mem_ack),
    .wb_valid (wb_valid),
    .state_q  (state_q),
    .op_q     (op_q),
    .lane     (lane)
);

`default_nettype wire

//--- testbench/mem_stage_tb.sv
`default_nettype none

module mem_stage_tb;

    localparam int N_RAND = 300;
    localparam int N_NONE = 16;
    // ld per word, 28 lane loads, non-loads, random mix
    localparam int N_OPS = mem_pkg::MEM_WORDS + 28 + N_NONE + N_RAND;
    localparam int LIMIT = N_OPS * (bus_pkg::RSP_DELAY + 6) + mem_pkg::MEM_WORDS + 1000;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    mem_pkg::stage_in_t in_op;
    logic               in_ready;
    logic               init_we;
    mem_pkg::word_idx_t init_idx;
    mem_pkg::xlen_t     init_data;
    logic               wb_valid;
    mem_pkg::wb_t       wb;

    logic [31:0]        lfsr;
    mem_pkg::xlen_t     model [mem_pkg::MEM_WORDS];
    // expected writebacks in acceptance order
    mem_pkg::wb_t       exp_q [$];
    int                 errors;
    int                 checks;
    int                 test_err;
    int                 cycles = 0;

    mem_stage_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_ready  (in_ready),
        .init_we   (init_we),
        .init_idx  (init_idx),
        .init_data (init_data),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // reference: pick bytes from the model word, then extend
    function automatic mem_pkg::wb_t model_wb(mem_pkg::stage_in_t op);
        mem_pkg::wb_t   r;
        mem_pkg::addr_t a;
        mem_pkg::xlen_t w;
        int             nb;
        int             ln;
        logic           sx;
        a = op.base + op.offset;
        w = model[a[10:3]];
        ln = int'(a[2:0]);
        nb = 8;
        if (op.kind == mem_pkg::LD_B || op.kind == mem_pkg::LD_BU) nb = 1;
        if (op.kind == mem_pkg::LD_H || op.kind == mem_pkg::LD_HU) nb = 2;
        if (op.kind == mem_pkg::LD_W || op.kind == mem_pkg::LD_WU) nb = 4;
        sx = op.kind inside {mem_pkg::LD_B, mem_pkg::LD_H, mem_pkg::LD_W};
        r.is_load = (op.kind != mem_pkg::LD_NONE);
        r.data = '0;
        if (!r.is_load) begin
            r.data = op.alu_res;
        end else begin
            for (int i = 0; i < nb; i++) begin
                r.data[8*i +: 8] = w[8*(ln+i) +: 8];
            end
            // fill upper bytes from the top loaded bit
            for (int i = nb; i < 8; i++) begin
                r.data[8*i +: 8] = (sx && r.data[8*nb-1]) ? 8'hff : 8'h00;
            end
        end
        return r;
    endfunction

    // random base, offset chosen to land on idx and lane
    function automatic mem_pkg::stage_in_t make_op(mem_pkg::load_kind_e k,
                                                   mem_pkg::word_idx_t idx,
                                                   mem_pkg::lane_t ln);
        mem_pkg::stage_in_t op;
        logic [63:0]        hi;
        op.kind = k;
        op.base = rand_bits(64);
        hi = rand_bits(53);
        op.offset = {hi[52:0], idx, ln} - op.base;
        op.alu_res = rand_bits(64);
        return op;
    endfunction

    task automatic check_wb(mem_pkg::wb_t got, mem_pkg::wb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: wb %h/%b, expected %h/%b", $time,
                     got.data, got.is_load, exp.data, exp.is_load);
        end
    endtask

    task automatic check_ready(logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: in_ready %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_valid(logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: wb_valid %b, expected %b", $time, got, exp);
        end
    endtask

    // in_ready is stable at the falling edge, so acceptance is known
    task automatic send_op(mem_pkg::stage_in_t op);
        @(negedge clk);
        in_valid = 1'b1;
        in_op = op;
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        exp_q.push_back(model_wb(op));
    endtask

    task automatic go_idle(int n);
        @(negedge clk);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic drain();
        go_idle(0);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(string name);
        $display("test %s: done, %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    // scoreboard, ready is high exactly when nothing is pending
    always @(negedge clk) begin
        if (rst_n) begin
            check_ready(in_ready, exp_q.size() == 0);
            if (wb_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("[ERROR] %0t: writeback with no operation pending", $time);
                end else begin
                    check_wb(wb, exp_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        mem_pkg::load_kind_e kind;
        mem_pkg::lane_t      ln;
        logic [63:0]         r;
        int                  step;
        lfsr = 32'd4;
        errors = 0;
        checks = 0;
        test_err = 0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_op = '0;
        init_we = 1'b0;
        init_idx = '0;
        init_data = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // 1: quiet after reset
        repeat (10) begin
            @(negedge clk);
            check_valid(wb_valid, 1'b0);
        end
        end_test("reset_idle");

        // 2: preload, then ld every word
        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
            @(negedge clk);
            init_we = 1'b1;
            init_idx = mem_pkg::word_idx_t'(i);
            init_data = rand_bits(64);
            model[i] = init_data;
        end
        @(negedge clk);
        init_we = 1'b0;
        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
            send_op(make_op(mem_pkg::LD_D, mem_pkg::word_idx_t'(i), 3'd0));
        end
        drain();
        end_test("ld_all_words");

        // 3: b, h and w kinds at every legal lane
        for (int k = 1; k < 7; k++) begin
            kind = mem_pkg::load_kind_e'(k[2:0]);
            step = (k <= 2) ? 1 : ((k <= 4) ? 2 : 4);
            for (int lane_i = 0; lane_i < 8; lane_i += step) begin
                r = rand_bits(8);
                send_op(make_op(kind, r[7:0], lane_i[2:0]));
            end
        end
        drain();
        end_test("lane_extend");

        // 4: non-load writes back one cycle after acceptance
        for (int i = 0; i < N_NONE; i++) begin
            send_op(make_op(mem_pkg::LD_NONE, '0, '0));
            @(negedge clk);
            in_valid = 1'b0;
            check_valid(wb_valid, 1'b1);
            @(negedge clk);
            check_valid(wb_valid, 1'b0);
        end
        end_test("non_load");

        // 5: random kinds, aligned lanes, random valid gaps
        for (int i = 0; i < N_RAND; i++) begin
            r = rand_bits(16);
            kind = mem_pkg::load_kind_e'(r[2:0]);
            ln = r[5:3];
            if (kind == mem_pkg::LD_H || kind == mem_pkg::LD_HU) ln[0] = 1'b0;
            if (kind == mem_pkg::LD_W || kind == mem_pkg::LD_WU) ln[1:0] = 2'b00;
            if (kind == mem_pkg::LD_D) ln = 3'd0;
            send_op(make_op(kind, r[13:6], ln));
            if (r[15:14] != 2'd0) go_idle(int'(r[15:14]) - 1);
        end
        drain();
        end_test("random_mix");

        errors = errors + dut0.u_ctrl.u_asserts.fails;
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
